// File: design/bridge_consts.svh
// bridge widths, register map and id word; include wherever these values are needed
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// bus widths
`define BRIDGE_ADDR_W   4
`define BRIDGE_DATA_W   32
`define BRIDGE_STRB_W   (`BRIDGE_DATA_W / 8)

// register byte offsets
`define REG_SCRATCH0    4'h0
`define REG_SCRATCH1    4'h4
`define REG_WCOUNT      4'h8
`define REG_ID          4'hC

// fixed identification word
`define BRIDGE_ID_VALUE 32'h5ca1_ab1e

// axi response codes
`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif

// File: design/bridge_pkg.sv
// shared bridge types; import by wildcard in the module header that uses them
`default_nettype none

`include "bridge_consts.svh"

package bridge_pkg;

    // ------------------------------------------------------------------
    // plain vector types
    // ------------------------------------------------------------------
    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0] data_t;
    typedef logic [`BRIDGE_STRB_W-1:0] strb_t;
    typedef logic [1:0]                resp_t;

    // ------------------------------------------------------------------
    // words carried across the clock crossings
    // ------------------------------------------------------------------

    // one bus access, bus side to core side
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } cmd_t;

    // result of one access, core side back to bus side
    typedef struct packed {
        data_t rdata;
        resp_t resp;
    } rsp_t;

endpackage

`default_nettype wire

// File: design/data_async.sv
// one-word ready/valid crossing between two clocks, one instance per direction
`timescale 1ns/1ps
`default_nettype none

module data_async #(
    parameter int ASYNC      = 1,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  s_reset,
    input  logic                  s_clk,
    input  logic [DATA_WIDTH-1:0] s_data,
    input  logic                  s_valid,
    output logic                  s_ready,

    input  logic                  m_reset,
    input  logic                  m_clk,
    output logic [DATA_WIDTH-1:0] m_data,
    output logic                  m_valid,
    input  logic                  m_ready
);

    generate
        if (ASYNC != 0) begin : g_async
            // sender side, s_clk
            logic                  s_req_q;
            logic                  s_ack_meta_q;
            logic                  s_ack_q;
            logic [DATA_WIDTH-1:0] s_data_q;

            // receiver side, m_clk
            logic                  m_req_meta_q;
            logic                  m_req_mid_q;
            logic                  m_req_q;
            logic                  m_ack_q;
            logic [DATA_WIDTH-1:0] m_data_q;

            // ----------------------------------------------------------
            // sender
            // ----------------------------------------------------------
            always_ff @(posedge s_clk) begin
                if (s_reset) begin
                    s_req_q      <= 1'b0;
                    s_ack_meta_q <= 1'b0;
                    s_ack_q      <= 1'b0;
                end else begin
                    // ack semaphore back from the receiver, two stages
                    s_ack_meta_q <= m_ack_q;
                    s_ack_q      <= s_ack_meta_q;
                    if (s_valid && s_ready) begin
                        s_req_q <= ~s_req_q;
                    end
                end
            end

            // held until the receiver has taken it
            always_ff @(posedge s_clk) begin
                if (s_valid && s_ready) begin
                    s_data_q <= s_data;
                end
            end

            assign s_ready = (s_req_q == s_ack_q);

            // ----------------------------------------------------------
            // receiver
            // ----------------------------------------------------------
            always_ff @(posedge m_clk) begin
                if (m_reset) begin
                    m_req_meta_q <= 1'b0;
                    m_req_mid_q  <= 1'b0;
                    m_req_q      <= 1'b0;
                    m_ack_q      <= 1'b0;
                end else begin
                    m_req_meta_q <= s_req_q;
                    m_req_mid_q  <= m_req_meta_q;
                    m_req_q      <= m_req_mid_q;
                    if (m_valid && m_ready) begin
                        m_ack_q <= ~m_ack_q;
                    end
                end
            end

            // sample the word on the edge the request toggle lands;
            // s_data_q has been still for two m_clk by then
            always_ff @(posedge m_clk) begin
                if (m_req_mid_q != m_req_q) begin
                    m_data_q <= s_data_q;
                end
            end

            assign m_data  = m_data_q;
            assign m_valid = (m_req_q != m_ack_q);
        end else begin : g_bypass
            // shared clock, straight through
            assign m_data  = s_data;
            assign m_valid = s_valid;
            assign s_ready = m_ready;
        end
    endgenerate

    // sender must hold its word until the crossing takes it
    a_s_data_stable: assert property (@(posedge s_clk) disable iff (s_reset)
        (s_valid && !s_ready) |=> (s_valid && $stable(s_data)));

endmodule

`default_nettype wire

// File: design/axil_cmd_slave.sv
// axi4-lite slave on s_clk, turns one access at a time into a command word and back
`timescale 1ns/1ps
`default_nettype none

module axil_cmd_slave
    import bridge_pkg::*;
(
    input  logic  s_clk,
    input  logic  s_reset,

    // write address and data
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,

    // write response
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,

    // read address and data
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,

    // command towards the core
    output cmd_t  cmd,
    output logic  cmd_valid,
    input  logic  cmd_ready,

    // response from the core
    input  rsp_t  rsp,
    input  logic  rsp_valid,
    output logic  rsp_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait_rsp,
        st_reply
    } state_t;

    state_t state_q;
    logic   pend_write_q;
    cmd_t   cmd_q;
    rsp_t   rsp_q;

    logic   rd_req;
    logic   wr_req;
    logic   take;
    logic   reply_done;
    cmd_t   bus_cmd;

    // ------------------------------------------------------------------
    // bus acceptance
    // ------------------------------------------------------------------

    // read wins when both arrive together
    assign rd_req = arvalid;
    assign wr_req = awvalid && wvalid && !arvalid;
    assign take   = (state_q == st_idle) && (rd_req || wr_req);

    assign arready = (state_q == st_idle) && rd_req;
    assign awready = (state_q == st_idle) && wr_req;
    assign wready  = (state_q == st_idle) && wr_req;

    always_comb begin
        bus_cmd.write = !arvalid;
        bus_cmd.addr  = arvalid ? araddr : awaddr;
        bus_cmd.wdata = arvalid ? '0 : wdata;
        bus_cmd.strb  = arvalid ? '0 : wstrb;
    end

    // straight from the bus in idle, from the latch while stalled
    assign cmd       = (state_q == st_issue) ? cmd_q : bus_cmd;
    assign cmd_valid = take || (state_q == st_issue);
    assign rsp_ready = (state_q == st_wait_rsp);

    // ------------------------------------------------------------------
    // reply channels
    // ------------------------------------------------------------------
    assign bvalid = (state_q == st_reply) && pend_write_q;
    assign rvalid = (state_q == st_reply) && !pend_write_q;
    assign bresp  = rsp_q.resp;
    assign rresp  = rsp_q.resp;
    assign rdata  = rsp_q.rdata;

    assign reply_done = (bvalid && bready) || (rvalid && rready);

    // ------------------------------------------------------------------
    // fsm
    // ------------------------------------------------------------------
    always_ff @(posedge s_clk) begin
        if (s_reset) begin
            state_q      <= st_idle;
            pend_write_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (take) begin
                        pend_write_q <= wr_req;
                        state_q      <= cmd_ready ? st_wait_rsp : st_issue;
                    end
                end
                st_issue: begin
                    if (cmd_ready) begin
                        state_q <= st_wait_rsp;
                    end
                end
                st_wait_rsp: begin
                    if (rsp_valid) begin
                        state_q <= st_reply;
                    end
                end
                st_reply: begin
                    if (reply_done) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // payload latches
    always_ff @(posedge s_clk) begin
        if (take) begin
            cmd_q <= bus_cmd;
        end
        if (rsp_valid && rsp_ready) begin
            rsp_q <= rsp;
        end
    end

    // a reply held by the master blocks the next command
    a_no_cmd_during_reply: assert property (@(posedge s_clk) disable iff (s_reset)
        ((bvalid && !bready) || (rvalid && !rready)) |=> !cmd_valid);

endmodule

`default_nettype wire

// File: design/core_regs.sv
// core-domain register file on m_clk, runs one command and answers with one response
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module core_regs
    import bridge_pkg::*;
(
    input  logic m_clk,
    input  logic m_reset,

    input  cmd_t cmd,
    input  logic cmd_valid,
    output logic cmd_ready,

    output rsp_t rsp,
    output logic rsp_valid,
    input  logic rsp_ready
);

    data_t scratch0_q;
    data_t scratch1_q;
    data_t wcount_q;
    rsp_t  rsp_q;
    logic  rsp_valid_q;

    logic  take;
    logic  known;
    data_t rd_word;

    // byte-wise merge under the strobe
    function automatic data_t merge(input data_t old_v, input data_t new_v,
                                    input strb_t strb);
        data_t res;
        res = old_v;
        for (int i = 0; i < `BRIDGE_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // idle while no response is waiting
    assign cmd_ready = !rsp_valid_q;
    assign take      = cmd_valid && cmd_ready;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------
    always_comb begin
        known   = 1'b1;
        rd_word = '0;
        case (cmd.addr)
            `REG_SCRATCH0: rd_word = scratch0_q;
            `REG_SCRATCH1: rd_word = scratch1_q;
            `REG_WCOUNT:   rd_word = wcount_q;
            `REG_ID:       rd_word = `BRIDGE_ID_VALUE;
            // unaligned or unmapped
            default:       known = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------
    always_ff @(posedge m_clk) begin
        if (m_reset) begin
            scratch0_q  <= '0;
            scratch1_q  <= '0;
            wcount_q    <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (take && cmd.write && known) begin
                wcount_q <= wcount_q + 1'b1;
                // read-only offsets ignore the data
                if (cmd.addr == `REG_SCRATCH0) begin
                    scratch0_q <= merge(scratch0_q, cmd.wdata, cmd.strb);
                end
                if (cmd.addr == `REG_SCRATCH1) begin
                    scratch1_q <= merge(scratch1_q, cmd.wdata, cmd.strb);
                end
            end
            if (take) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge m_clk) begin
        if (take) begin
            rsp_q.rdata <= (known && !cmd.write) ? rd_word : '0;
            rsp_q.resp  <= known ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

    assign rsp       = rsp_q;
    assign rsp_valid = rsp_valid_q;

    // response stays put until the crossing takes it
    a_rsp_held: assert property (@(posedge m_clk) disable iff (m_reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)));

endmodule

`default_nettype wire

// File: design/reg_bridge_top.sv
// bridge top level, axi4-lite on s_clk to the register file on m_clk
`timescale 1ns/1ps
`default_nettype none

module reg_bridge_top
    import bridge_pkg::*;
#(
    parameter int ASYNC = 1
) (
    input  logic  s_clk,
    input  logic  s_reset,
    input  logic  m_clk,
    input  logic  m_reset,

    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready
);

    // bus side
    cmd_t cmd_s;
    logic cmd_s_valid;
    logic cmd_s_ready;
    rsp_t rsp_s;
    logic rsp_s_valid;
    logic rsp_s_ready;

    // core side
    cmd_t cmd_m;
    logic cmd_m_valid;
    logic cmd_m_ready;
    rsp_t rsp_m;
    logic rsp_m_valid;
    logic rsp_m_ready;

    axil_cmd_slave u_slave (
        .s_clk     (s_clk),
        .s_reset   (s_reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .cmd       (cmd_s),
        .cmd_valid (cmd_s_valid),
        .cmd_ready (cmd_s_ready),
        .rsp       (rsp_s),
        .rsp_valid (rsp_s_valid),
        .rsp_ready (rsp_s_ready)
    );

    // ------------------------------------------------------------------
    // command s_clk to m_clk, response m_clk to s_clk
    // ------------------------------------------------------------------
    data_async #(
        .ASYNC      (ASYNC),
        .DATA_WIDTH ($bits(cmd_t))
    ) u_cmd_cdc (
        .s_reset (s_reset),
        .s_clk   (s_clk),
        .s_data  (cmd_s),
        .s_valid (cmd_s_valid),
        .s_ready (cmd_s_ready),
        .m_reset (m_reset),
        .m_clk   (m_clk),
        .m_data  (cmd_m),
        .m_valid (cmd_m_valid),
        .m_ready (cmd_m_ready)
    );

    data_async #(
        .ASYNC      (ASYNC),
        .DATA_WIDTH ($bits(rsp_t))
    ) u_rsp_cdc (
        .s_reset (m_reset),
        .s_clk   (m_clk),
        .s_data  (rsp_m),
        .s_valid (rsp_m_valid),
        .s_ready (rsp_m_ready),
        .m_reset (s_reset),
        .m_clk   (s_clk),
        .m_data  (rsp_s),
        .m_valid (rsp_s_valid),
        .m_ready (rsp_s_ready)
    );

    core_regs u_regs (
        .m_clk     (m_clk),
        .m_reset   (m_reset),
        .cmd       (cmd_m),
        .cmd_valid (cmd_m_valid),
        .cmd_ready (cmd_m_ready),
        .rsp       (rsp_m),
        .rsp_valid (rsp_m_valid),
        .rsp_ready (rsp_m_ready)
    );

endmodule

`default_nettype wire

// File: tests/tb_reg_bridge.sv
// testbench for the register bridge; applies a table of bus accesses and checks every reply
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module tb_reg_bridge
    import bridge_pkg::*;
;

    localparam int M_PERIOD  = 40;
    localparam int S_PERIOD  = 30;
    localparam int NUM_TESTS = 20;
    localparam int SEED      = 32'heb3e_4a04;

    // one table row, the name lives in a separate array
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t exp_data;
        resp_t exp_resp;
    } entry_t;

    logic  m_clk;
    logic  m_reset;
    logic  s_clk;
    logic  s_reset;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    entry_t tbl [NUM_TESTS];
    string  names [NUM_TESTS];
    int     n_entries;
    int     errors;
    int     failed_tests;
    data_t  wr_count;

    reg_bridge_top #(
        .ASYNC (1)
    ) UUT (
        .s_clk   (s_clk),
        .s_reset (s_reset),
        .m_clk   (m_clk),
        .m_reset (m_reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(M_PERIOD / 2) m_clk = ~m_clk;
    always #(S_PERIOD / 2) s_clk = ~s_clk;

    // ------------------------------------------------------------------
    // table and bus tasks
    // ------------------------------------------------------------------
    task automatic add_entry(input string name, input logic write, input addr_t addr,
                             input data_t wd, input strb_t strb, input data_t exp_data,
                             input resp_t exp_resp);
        names[n_entries]          = name;
        tbl[n_entries].write      = write;
        tbl[n_entries].addr       = addr;
        tbl[n_entries].wdata      = wd;
        tbl[n_entries].strb       = strb;
        tbl[n_entries].exp_data   = exp_data;
        tbl[n_entries].exp_resp   = exp_resp;
        n_entries++;
    endtask

    // waits for B or R, holds ready low for a random 0 to 3 cycles
    task automatic take_reply(input logic is_write, output data_t data, output resp_t resp);
        int hold;
        hold = int'($urandom % 4);
        while (!bvalid && !rvalid) begin
            @(negedge s_clk);
        end
        if (is_write ? rvalid : bvalid) begin
            $display("Reply arrived on the wrong channel");
            errors++;
        end
        repeat (hold) @(negedge s_clk);
        data = rdata;
        resp = is_write ? bresp : rresp;
        // accept whatever reply is pending so the run can go on
        bready = bvalid;
        rready = rvalid;
        @(negedge s_clk);
        bready = 1'b0;
        rready = 1'b0;
        if (bvalid || rvalid) begin
            $display("Reply still valid after the handshake");
            errors++;
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t wd, input strb_t strb,
                             output resp_t resp);
        data_t unused;
        @(negedge s_clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = wd;
        wstrb   = strb;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge s_clk);
            #1;
        end
        @(negedge s_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        take_reply(1'b1, unused, resp);
    endtask

    task automatic bus_read(input addr_t addr, output data_t data, output resp_t resp);
        @(negedge s_clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge s_clk);
            #1;
        end
        @(negedge s_clk);
        arvalid = 1'b0;
        take_reply(1'b0, data, resp);
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        data_t  got_data;
        resp_t  got_resp;
        data_t  exp_data;
        int     errs_before;
        e = tbl[idx];
        errs_before = errors;
        if (e.write) begin
            bus_write(e.addr, e.wdata, e.strb, got_resp);
            // every aligned offset is in range and counts
            if (e.addr[1:0] == 2'b00) begin
                wr_count = wr_count + 32'd1;
            end
        end else begin
            bus_read(e.addr, got_data, got_resp);
            exp_data = (e.addr == `REG_WCOUNT) ? wr_count : e.exp_data;
            if (got_data !== exp_data) begin
                $display("Mismatch %0s: data expected %h actual %h",
                         names[idx], exp_data, got_data);
                errors++;
            end
        end
        if (got_resp !== e.exp_resp) begin
            $display("Mismatch %0s: resp expected %h actual %h",
                     names[idx], e.exp_resp, got_resp);
            errors++;
        end
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("%-20s %0s", names[idx], (errors == errs_before) ? "ok" : "failed");
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        m_clk = 1'b0;
        s_clk = 1'b0;
        m_reset = 1'b1;
        s_reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        n_entries = 0;
        errors = 0;
        failed_tests = 0;
        wr_count = '0;
        void'($urandom(SEED));

        add_entry("id_after_reset", 1'b0, `REG_ID, '0, '0, `BRIDGE_ID_VALUE, `RESP_OKAY);
        add_entry("scr0_after_reset", 1'b0, `REG_SCRATCH0, '0, '0, '0, `RESP_OKAY);
        add_entry("scr1_after_reset", 1'b0, `REG_SCRATCH1, '0, '0, '0, `RESP_OKAY);
        add_entry("wcount_after_reset", 1'b0, `REG_WCOUNT, '0, '0, '0, `RESP_OKAY);
        add_entry("scr0_write_full", 1'b1, `REG_SCRATCH0, 32'h1234_5678, 4'hf, '0, `RESP_OKAY);
        add_entry("scr0_read_full", 1'b0, `REG_SCRATCH0, '0, '0, 32'h1234_5678, `RESP_OKAY);
        add_entry("scr1_write_full", 1'b1, `REG_SCRATCH1, 32'hdead_beef, 4'hf, '0, `RESP_OKAY);
        add_entry("scr1_read_full", 1'b0, `REG_SCRATCH1, '0, '0, 32'hdead_beef, `RESP_OKAY);
        // byte 1 only
        add_entry("scr0_write_byte1", 1'b1, `REG_SCRATCH0, 32'haabb_ccdd, 4'h2, '0, `RESP_OKAY);
        add_entry("scr0_read_byte1", 1'b0, `REG_SCRATCH0, '0, '0, 32'h1234_cc78, `RESP_OKAY);
        // bytes 3 and 0
        add_entry("scr1_write_ends", 1'b1, `REG_SCRATCH1, 32'h1100_0022, 4'h9, '0, `RESP_OKAY);
        add_entry("scr1_read_ends", 1'b0, `REG_SCRATCH1, '0, '0, 32'h11ad_be22, `RESP_OKAY);
        add_entry("id_write", 1'b1, `REG_ID, 32'hffff_ffff, 4'hf, '0, `RESP_OKAY);
        add_entry("id_read_back", 1'b0, `REG_ID, '0, '0, `BRIDGE_ID_VALUE, `RESP_OKAY);
        add_entry("wcount_read", 1'b0, `REG_WCOUNT, '0, '0, '0, `RESP_OKAY);
        add_entry("unaligned_write", 1'b1, 4'h2, 32'hffff_ffff, 4'hf, '0, `RESP_SLVERR);
        add_entry("unaligned_read_6", 1'b0, 4'h6, '0, '0, '0, `RESP_SLVERR);
        add_entry("unaligned_read_b", 1'b0, 4'hb, '0, '0, '0, `RESP_SLVERR);
        add_entry("scr0_unchanged", 1'b0, `REG_SCRATCH0, '0, '0, 32'h1234_cc78, `RESP_OKAY);
        add_entry("wcount_final", 1'b0, `REG_WCOUNT, '0, '0, '0, `RESP_OKAY);

        repeat (5) @(negedge m_clk);
        m_reset = 1'b0;
        @(negedge s_clk);
        s_reset = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_entries, n_entries - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // generous bound per table entry, measured in core clock periods
    initial begin
        #(NUM_TESTS * 200 * M_PERIOD);
        $display("Watchdog expired before the table finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/bridge_pkg.sv
design/data_async.sv
design/axil_cmd_slave.sv
design/core_regs.sv
design/reg_bridge_top.sv
tests/tb_reg_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_reg_bridge \
    -f project.f

./obj_dir/Vtb_reg_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
